// ==== dcache_pkg.sv ====
// Shared definitions for the data cache pipeline
// Cache geometry, op and size encodings, address union and pipeline structs

`default_nettype none

package dcache_pkg;

    // Cache geometry
    localparam int DATA_WIDTH   = 32;
    localparam int DATA_SIZE    = DATA_WIDTH / 8;
    localparam int ADDR_WIDTH   = 16;
    localparam int LINE_SIZE    = 16;
    localparam int LINE_WIDTH   = LINE_SIZE * 8;
    localparam int CACHE_SIZE   = 256;
    localparam int LINE_COUNT   = CACHE_SIZE / LINE_SIZE;
    localparam int OFFSET_WIDTH = $clog2(LINE_SIZE);
    localparam int INDEX_WIDTH  = $clog2(LINE_COUNT);
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef enum logic [1:0] {
        OP_NONE  = 2'b00,
        OP_LOAD  = 2'b01,
        OP_STORE = 2'b10,
        OP_FILL  = 2'b11
    } dc_op_e;

    // Encoding 2'b11 is left unused
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } dc_size_e;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
    } dc_addr_fields_t;

    // A byte address seen either as one word or split into its fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] word;
        dc_addr_fields_t       fields;
    } dc_addr_u;

    typedef struct packed {
        logic                  valid;
        dc_op_e                op;
        logic [ADDR_WIDTH-1:0] addr;
        dc_size_e              size;
        logic [DATA_WIDTH-1:0] data;
        logic [LINE_WIDTH-1:0] fill_data;
    } dc_req_t;

    typedef struct packed {
        logic                    valid;
        dc_op_e                  op;
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
        logic [DATA_SIZE-1:0]    byte_sel;
        logic [DATA_WIDTH-1:0]   data;
        logic [LINE_WIDTH-1:0]   fill_data;
        logic                    wr_valid;
        logic                    wr_dirty;
    } dc_stage_t;

    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [TAG_WIDTH-1:0]  tag;
        logic [LINE_WIDTH-1:0] data;
    } dc_line_t;

    typedef struct packed {
        logic                   en;
        logic [INDEX_WIDTH-1:0] index;
        dc_line_t               line;
    } dc_wr_t;

    typedef struct packed {
        logic                  valid;
        logic                  hit;
        logic [DATA_WIDTH-1:0] data;
        logic                  victim_valid;
        logic [ADDR_WIDTH-1:0] victim_addr;
        logic [LINE_WIDTH-1:0] victim_data;
    } dc_rsp_t;

endpackage

`default_nettype wire

// ==== dcache_ram.sv ====
// Direct-mapped tag, state and line storage
// One synchronous write-first read port and one write port

`timescale 1ns/1ps
`default_nettype none

module dcache_ram (
    input  wire logic                                clk,
    input  wire logic                                i_reset,
    input  wire logic [dcache_pkg::INDEX_WIDTH-1:0]  i_rd_index,
    output dcache_pkg::dc_line_t                     o_rd_line,
    input  dcache_pkg::dc_wr_t                       i_wr
);

    logic [dcache_pkg::TAG_WIDTH-1:0]  tag_mem  [dcache_pkg::LINE_COUNT];
    logic [dcache_pkg::LINE_WIDTH-1:0] data_mem [dcache_pkg::LINE_COUNT];
    logic [dcache_pkg::LINE_COUNT-1:0] valid_q;
    logic [dcache_pkg::LINE_COUNT-1:0] dirty_q;
    logic                              rd_fwd;

    // A read of the set being written this cycle sees the new entry
    assign rd_fwd = i_wr.en & (i_wr.index == i_rd_index);

    // Tag and line payload
    always_ff @(posedge clk) begin
        if (i_wr.en) begin
            tag_mem[i_wr.index]  <= i_wr.line.tag;
            data_mem[i_wr.index] <= i_wr.line.data;
        end
    end

    // State bits must come up invalid and clean
    always_ff @(posedge clk) begin
        if (i_reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_wr.en) begin
            valid_q[i_wr.index] <= i_wr.line.valid;
            dirty_q[i_wr.index] <= i_wr.line.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fwd) begin
            o_rd_line <= i_wr.line;
        end else begin
            o_rd_line.valid <= valid_q[i_rd_index];
            o_rd_line.dirty <= dirty_q[i_rd_index];
            o_rd_line.tag   <= tag_mem[i_rd_index];
            o_rd_line.data  <= data_mem[i_rd_index];
        end

        if (i_reset) begin
            o_rd_line.valid <= 1'b0;
            o_rd_line.dirty <= 1'b0;
        end
    end

    // A dirty line is always a valid line
    a_dirty_implies_valid: assert property (
        @(posedge clk) disable iff (i_reset)
        ~|(dirty_q & ~valid_q)
    );

endmodule

`default_nettype wire

// ==== dcache_ac.sv ====
// Address stage of the data cache pipeline
// Splits the address, builds the byte select and state bits, registers the op

`timescale 1ns/1ps
`default_nettype none

module dcache_ac (
    input  wire logic                                clk,
    input  wire logic                                i_reset,
    input  dcache_pkg::dc_req_t                      i_req,
    output logic [dcache_pkg::INDEX_WIDTH-1:0]       o_rd_index,
    output dcache_pkg::dc_stage_t                    o_stage
);

    dcache_pkg::dc_addr_u               addr;
    logic [dcache_pkg::DATA_SIZE-1:0]   byte_sel;
    dcache_pkg::dc_stage_t              stage_d;

    assign addr.word = i_req.addr;

    // The array read starts in the same cycle as the request
    assign o_rd_index = addr.fields.index;

    // Byte select always starts at the lowest byte of the word
    always_comb begin
        case (i_req.size)
            dcache_pkg::SIZE_BYTE: byte_sel = {{(dcache_pkg::DATA_SIZE-1){1'b0}}, 1'b1};
            dcache_pkg::SIZE_HALF: byte_sel = {{(dcache_pkg::DATA_SIZE-2){1'b0}}, 2'b11};
            dcache_pkg::SIZE_WORD: byte_sel = '1;
            default:               byte_sel = '0;
        endcase
    end

    always_comb begin
        stage_d.valid     = i_req.valid;
        stage_d.op        = i_req.op;
        stage_d.tag       = addr.fields.tag;
        stage_d.index     = addr.fields.index;
        stage_d.offset    = addr.fields.offset;
        stage_d.byte_sel  = byte_sel;
        stage_d.data      = i_req.data;
        stage_d.fill_data = i_req.fill_data;
        // Stores leave the line dirty, fills bring it in clean
        stage_d.wr_valid  = (i_req.op == dcache_pkg::OP_STORE) |
                            (i_req.op == dcache_pkg::OP_FILL);
        stage_d.wr_dirty  = (i_req.op == dcache_pkg::OP_STORE);
    end

    always_ff @(posedge clk) begin
        o_stage <= stage_d;
        if (i_reset) begin
            o_stage.valid <= 1'b0;
        end
    end

    a_size_legal: assert property (
        @(posedge clk) disable iff (i_reset)
        i_req.valid |-> (i_req.size != dcache_pkg::dc_size_e'(2'b11))
    );

endmodule

`default_nettype wire

// ==== dcache_dw.sv ====
// Hit and write stage of the data cache pipeline
// Bypass, hit check, load extraction, store merge, fill mux and victim output

`timescale 1ns/1ps
`default_nettype none

module dcache_dw (
    input  wire logic              clk,
    input  wire logic              i_reset,
    input  dcache_pkg::dc_stage_t  i_stage,
    input  dcache_pkg::dc_line_t   i_rd_line,
    output dcache_pkg::dc_wr_t     o_wr,
    output dcache_pkg::dc_rsp_t    o_rsp
);

    logic                                                   bypass;
    logic                                                   bypass_tag_match;
    dcache_pkg::dc_line_t                                   cur_line;
    logic                                                   cache_hit;
    logic                                                   is_fill;
    logic                                                   is_store;
    logic                                                   wr_en;
    logic [dcache_pkg::DATA_WIDTH-1:0]                      be_mask;
    logic [dcache_pkg::OFFSET_WIDTH+2:0]                    bit_shift;
    logic [dcache_pkg::LINE_WIDTH+dcache_pkg::DATA_WIDTH-1:0] ld_window;
    logic [dcache_pkg::DATA_WIDTH-1:0]                      ld_data;
    logic [dcache_pkg::LINE_WIDTH+dcache_pkg::DATA_WIDTH-1:0] st_mask_wide;
    logic [dcache_pkg::LINE_WIDTH+dcache_pkg::DATA_WIDTH-1:0] st_data_wide;
    logic [dcache_pkg::LINE_WIDTH-1:0]                      st_line;
    logic [dcache_pkg::LINE_WIDTH-1:0]                      wr_data;
    dcache_pkg::dc_addr_u                                   victim_addr;
    logic                                                   victim_valid;
    logic [dcache_pkg::LINE_WIDTH-1:0]                      victim_data;

    assign is_fill  = (i_stage.op == dcache_pkg::OP_FILL);
    assign is_store = (i_stage.op == dcache_pkg::OP_STORE);

    // The previous op's write lands in the array at the end of this cycle,
    // so the read entry is stale when that write hits the same set
    assign bypass           = o_wr.en & (o_wr.index == i_stage.index);
    assign bypass_tag_match = bypass & (o_wr.line.tag == i_stage.tag);

    always_comb begin
        cur_line.valid = bypass ? o_wr.line.valid : i_rd_line.valid;
        cur_line.dirty = bypass ? o_wr.line.dirty : i_rd_line.dirty;
        cur_line.tag   = bypass ? o_wr.line.tag   : i_rd_line.tag;
        cur_line.data  = bypass_tag_match ? o_wr.line.data : i_rd_line.data;
    end

    assign cache_hit = cur_line.valid & (cur_line.tag == i_stage.tag);

    // Fills always write, stores only when they hit
    assign wr_en = i_stage.valid & (is_fill | (is_store & cache_hit));

    // Expand the byte select into a bit mask over one data word
    always_comb begin
        for (int j = 0; j < dcache_pkg::DATA_SIZE; j++) begin
            be_mask[j*8 +: 8] = {8{i_stage.byte_sel[j]}};
        end
    end

    assign bit_shift = {i_stage.offset, 3'b000};

    // The zero word above the line makes bytes past the line end read as zero
    assign ld_window = {{dcache_pkg::DATA_WIDTH{1'b0}}, cur_line.data} >> bit_shift;
    assign ld_data   = ld_window[dcache_pkg::DATA_WIDTH-1:0] & be_mask;

    // Store bytes shifted past the line end fall off the top and are dropped
    assign st_mask_wide = {{dcache_pkg::LINE_WIDTH{1'b0}}, be_mask} << bit_shift;
    assign st_data_wide = {{dcache_pkg::LINE_WIDTH{1'b0}}, i_stage.data & be_mask} << bit_shift;

    assign st_line = (cur_line.data & ~st_mask_wide[dcache_pkg::LINE_WIDTH-1:0]) |
                     st_data_wide[dcache_pkg::LINE_WIDTH-1:0];

    assign wr_data = is_fill ? i_stage.fill_data : st_line;

    // Victim address points at the start of the replaced line
    always_comb begin
        victim_addr.fields.tag    = cur_line.tag;
        victim_addr.fields.index  = i_stage.index;
        victim_addr.fields.offset = '0;
    end

    // Only dirty victims need a writeback
    assign victim_valid = i_stage.valid & is_fill & cur_line.valid & cur_line.dirty;

    // The whole line being written is the victim when bypassing, whatever its tag
    assign victim_data = bypass ? o_wr.line.data : i_rd_line.data;

    always_ff @(posedge clk) begin
        o_wr.index      <= i_stage.index;
        o_wr.line.valid <= i_stage.wr_valid;
        o_wr.line.dirty <= i_stage.wr_dirty;
        o_wr.line.tag   <= i_stage.tag;
        o_wr.line.data  <= wr_data;

        o_rsp.data        <= ld_data;
        o_rsp.victim_addr <= victim_addr.word;
        o_rsp.victim_data <= victim_data;

        if (i_reset) begin
            o_wr.en            <= 1'b0;
            o_rsp.valid        <= 1'b0;
            o_rsp.hit          <= 1'b0;
            o_rsp.victim_valid <= 1'b0;
        end else begin
            o_wr.en            <= wr_en;
            o_rsp.valid        <= i_stage.valid;
            o_rsp.hit          <= i_stage.valid & cache_hit;
            o_rsp.victim_valid <= victim_valid;
        end
    end

    // A victim can only come out of a fill issued the cycle before
    a_victim_from_fill: assert property (
        @(posedge clk) disable iff (i_reset)
        o_rsp.victim_valid |-> ($past(i_stage.op) == dcache_pkg::OP_FILL)
    );

    // Every array write belongs to an op that is responding
    a_write_has_rsp: assert property (
        @(posedge clk) disable iff (i_reset)
        o_wr.en |-> o_rsp.valid
    );

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
// Top level of the data cache pipeline
// Address stage, line arrays and hit and write stage

`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire logic            clk,
    input  wire logic            i_reset,
    input  dcache_pkg::dc_req_t  i_req,
    output dcache_pkg::dc_rsp_t  o_rsp
);

    logic [dcache_pkg::INDEX_WIDTH-1:0] rd_index;
    dcache_pkg::dc_stage_t              stage;
    dcache_pkg::dc_line_t               rd_line;
    dcache_pkg::dc_wr_t                 wr;

    dcache_ac dcache_ac_inst (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_req      (i_req),
        .o_rd_index (rd_index),
        .o_stage    (stage)
    );

    dcache_ram dcache_ram_inst (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_rd_index (rd_index),
        .o_rd_line  (rd_line),
        .i_wr       (wr)
    );

    // The write struct also serves as the bypass source inside dcache_dw
    dcache_dw dcache_dw_inst (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_stage   (stage),
        .i_rd_line (rd_line),
        .o_wr      (wr),
        .o_rsp     (o_rsp)
    );

endmodule

`default_nettype wire

// ==== tb_dcache_top.sv ====
// Directed testbench for the data cache pipeline
// Reference model of the line entries, response checker and one task per test

`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top;

    typedef struct packed {
        logic [31:0]         due;
        logic                cmp_data;
        dcache_pkg::dc_rsp_t rsp;
    } expect_t;

    logic                 clk;
    logic                 i_reset;
    dcache_pkg::dc_req_t  i_req;
    dcache_pkg::dc_rsp_t  o_rsp;

    dcache_pkg::dc_line_t model_mem [dcache_pkg::LINE_COUNT];
    expect_t              exp_q [$];
    int unsigned          edge_count = 0;
    int                   err_count = 0;
    int                   check_count = 0;
    integer               seed = 32'hb353;

    dcache_top dcache_top_inst (
        .clk     (clk),
        .i_reset (i_reset),
        .i_req   (i_req),
        .o_rsp   (o_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [dcache_pkg::LINE_WIDTH-1:0] rand_line();
        return {rand_word(), rand_word(), rand_word(), rand_word()};
    endfunction

    function automatic logic [dcache_pkg::ADDR_WIDTH-1:0] line_addr(
        input logic [7:0] tag, input logic [3:0] index, input logic [3:0] offset);
        return {tag, index, offset};
    endfunction

    // Applies one op to the model in issue order and builds its expected response
    task automatic model_op(input dcache_pkg::dc_req_t req, output expect_t e);
        dcache_pkg::dc_addr_u addr;
        dcache_pkg::dc_line_t ent;
        int                   nbytes;
        int                   pos;
        logic                 hit;
        addr.word = req.addr;
        ent = model_mem[addr.fields.index];
        hit = ent.valid && (ent.tag == addr.fields.tag);
        nbytes = (req.size == dcache_pkg::SIZE_BYTE) ? 1 :
                 (req.size == dcache_pkg::SIZE_HALF) ? 2 : 4;
        e = '0;
        e.rsp.valid = 1'b1;
        e.rsp.hit = hit;
        e.cmp_data = hit && (req.op == dcache_pkg::OP_LOAD);
        for (int j = 0; j < nbytes; j++) begin
            pos = int'(addr.fields.offset) + j;
            // Bytes past the end of the line are neither read nor written
            if (pos < dcache_pkg::LINE_SIZE) begin
                if (req.op == dcache_pkg::OP_LOAD) begin
                    e.rsp.data[j*8 +: 8] = ent.data[pos*8 +: 8];
                end else if (req.op == dcache_pkg::OP_STORE && hit) begin
                    ent.data[pos*8 +: 8] = req.data[j*8 +: 8];
                end
            end
        end
        if (req.op == dcache_pkg::OP_STORE && hit) begin
            ent.dirty = 1'b1;
        end
        if (req.op == dcache_pkg::OP_FILL) begin
            e.rsp.victim_valid = ent.valid && ent.dirty;
            e.rsp.victim_addr = {ent.tag, addr.fields.index, {dcache_pkg::OFFSET_WIDTH{1'b0}}};
            e.rsp.victim_data = ent.data;
            ent.valid = 1'b1;
            ent.dirty = 1'b0;
            ent.tag = addr.fields.tag;
            ent.data = req.fill_data;
        end
        model_mem[addr.fields.index] = ent;
    endtask

    task automatic issue_op(input dcache_pkg::dc_op_e op, input logic [15:0] addr,
                            input dcache_pkg::dc_size_e size, input logic [31:0] data,
                            input logic [127:0] fill);
        dcache_pkg::dc_req_t req;
        expect_t             e;
        req.valid = 1'b1;
        req.op = op;
        req.addr = addr;
        req.size = size;
        req.data = data;
        req.fill_data = fill;
        @(posedge clk);
        i_req <= req;
        model_op(req, e);
        // The response shows up after the stage and output registers
        e.due = edge_count + 3;
        exp_q.push_back(e);
    endtask

    task automatic send_load(input logic [15:0] addr, input dcache_pkg::dc_size_e size);
        issue_op(dcache_pkg::OP_LOAD, addr, size, '0, '0);
    endtask

    task automatic send_store(input logic [15:0] addr, input dcache_pkg::dc_size_e size,
                              input logic [31:0] data);
        issue_op(dcache_pkg::OP_STORE, addr, size, data, '0);
    endtask

    task automatic send_fill(input logic [15:0] addr, input logic [127:0] line);
        issue_op(dcache_pkg::OP_FILL, addr, dcache_pkg::SIZE_WORD, '0, line);
    endtask

    // Stops issuing and waits until every queued response has been checked
    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        i_req.valid <= 1'b0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d responses did not arrive within 20 cycles", exp_q.size());
            err_count++;
            exp_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %s finished with %0d errors", name, err_count - errs_before);
    endtask

    always @(negedge clk) begin : check_rsp
        expect_t e;
        if (!i_reset) begin
            if (exp_q.size() != 0 && exp_q[0].due == edge_count) begin
                e = exp_q.pop_front();
                check_value("o_rsp.valid", 128'(o_rsp.valid), 128'(1'b1));
                check_value("o_rsp.hit", 128'(o_rsp.hit), 128'(e.rsp.hit));
                check_value("o_rsp.victim_valid", 128'(o_rsp.victim_valid),
                            128'(e.rsp.victim_valid));
                if (e.cmp_data) begin
                    check_value("o_rsp.data", 128'(o_rsp.data), 128'(e.rsp.data));
                end
                if (e.rsp.victim_valid) begin
                    check_value("o_rsp.victim_addr", 128'(o_rsp.victim_addr),
                                128'(e.rsp.victim_addr));
                    check_value("o_rsp.victim_data", o_rsp.victim_data, e.rsp.victim_data);
                end
            end else if (o_rsp.valid !== 1'b0) begin
                $display("Error: a response arrived at cycle %0d with no op due", edge_count);
                err_count++;
            end
        end
    end

    task automatic test_after_reset();
        int          errs;
        logic [31:0] w;
        errs = err_count;
        // Idle cycles where any response is flagged by the checker
        repeat (8) @(posedge clk);
        w = rand_word();
        send_load(w[15:0], dcache_pkg::SIZE_WORD);
        send_store(w[15:0], dcache_pkg::SIZE_WORD, rand_word());
        send_load(w[15:0], dcache_pkg::SIZE_WORD);
        drain();
        report_test("after_reset", errs);
    endtask

    task automatic test_fill_load();
        int errs;
        errs = err_count;
        for (int s = 0; s < 6; s++) begin
            send_fill(line_addr(8'h40 + 8'(s), 4'(s), 4'h0), rand_line());
        end
        for (int s = 0; s < 6; s++) begin
            send_load(line_addr(8'h40 + 8'(s), 4'(s), 4'(s * 2)), dcache_pkg::SIZE_WORD);
            send_load(line_addr(8'h40 + 8'(s), 4'(s), 4'(s + 1)), dcache_pkg::SIZE_HALF);
            send_load(line_addr(8'h40 + 8'(s), 4'(s), 4'(s + 7)), dcache_pkg::SIZE_BYTE);
        end
        send_load(line_addr(8'h41, 4'd0, 4'd0), dcache_pkg::SIZE_WORD);
        drain();
        report_test("fill_load", errs);
    endtask

    task automatic test_store();
        int errs;
        errs = err_count;
        send_store(line_addr(8'h42, 4'd2, 4'd4), dcache_pkg::SIZE_WORD, rand_word());
        send_store(line_addr(8'h42, 4'd2, 4'd9), dcache_pkg::SIZE_HALF, rand_word());
        send_store(line_addr(8'h42, 4'd2, 4'd0), dcache_pkg::SIZE_BYTE, rand_word());
        drain();
        for (int off = 0; off < 16; off += 4) begin
            send_load(line_addr(8'h42, 4'd2, 4'(off)), dcache_pkg::SIZE_WORD);
        end
        // Wrong tag, so the line in set 3 must stay as filled
        send_store(line_addr(8'h99, 4'd3, 4'd4), dcache_pkg::SIZE_WORD, rand_word());
        drain();
        send_load(line_addr(8'h43, 4'd3, 4'd4), dcache_pkg::SIZE_WORD);
        drain();
        report_test("store", errs);
    endtask

    task automatic test_back_to_back();
        int errs;
        errs = err_count;
        send_fill(line_addr(8'h17, 4'd7, 4'd0), rand_line());
        drain();
        send_store(line_addr(8'h17, 4'd7, 4'd0), dcache_pkg::SIZE_WORD, rand_word());
        send_load(line_addr(8'h17, 4'd7, 4'd0), dcache_pkg::SIZE_WORD);
        drain();
        send_store(line_addr(8'h17, 4'd7, 4'd8), dcache_pkg::SIZE_WORD, rand_word());
        send_store(line_addr(8'h17, 4'd7, 4'd10), dcache_pkg::SIZE_HALF, rand_word());
        send_load(line_addr(8'h17, 4'd7, 4'd8), dcache_pkg::SIZE_WORD);
        send_load(line_addr(8'h17, 4'd7, 4'd10), dcache_pkg::SIZE_WORD);
        drain();
        // The victim of this fill must carry the store just ahead of it
        send_store(line_addr(8'h17, 4'd7, 4'd4), dcache_pkg::SIZE_WORD, rand_word());
        send_fill(line_addr(8'h18, 4'd7, 4'd0), rand_line());
        send_load(line_addr(8'h18, 4'd7, 4'd4), dcache_pkg::SIZE_WORD);
        drain();
        report_test("back_to_back", errs);
    endtask

    task automatic test_replace();
        int errs;
        errs = err_count;
        send_fill(line_addr(8'h21, 4'd9, 4'd0), rand_line());
        drain();
        send_store(line_addr(8'h21, 4'd9, 4'd4), dcache_pkg::SIZE_WORD, rand_word());
        drain();
        send_fill(line_addr(8'h22, 4'd9, 4'd0), rand_line());
        drain();
        send_fill(line_addr(8'h23, 4'd9, 4'd0), rand_line());
        drain();
        report_test("replace", errs);
    endtask

    task automatic test_line_end();
        int errs;
        errs = err_count;
        send_fill(line_addr(8'h31, 4'd11, 4'd0), rand_line());
        send_fill(line_addr(8'h32, 4'd12, 4'd0), rand_line());
        for (int off = 13; off < 16; off++) begin
            send_load(line_addr(8'h31, 4'd11, 4'(off)), dcache_pkg::SIZE_WORD);
        end
        for (int off = 13; off < 16; off++) begin
            send_store(line_addr(8'h31, 4'd11, 4'(off)), dcache_pkg::SIZE_WORD, rand_word());
        end
        drain();
        for (int off = 12; off < 16; off++) begin
            send_load(line_addr(8'h31, 4'd11, 4'(off)), dcache_pkg::SIZE_WORD);
        end
        send_load(line_addr(8'h32, 4'd12, 4'd0), dcache_pkg::SIZE_WORD);
        send_load(line_addr(8'h32, 4'd12, 4'd4), dcache_pkg::SIZE_WORD);
        drain();
        report_test("line_end", errs);
    endtask

    initial begin
        i_reset <= 1'b1;
        i_req   <= '0;
        for (int i = 0; i < dcache_pkg::LINE_COUNT; i++) begin
            model_mem[i] = '0;
        end
        repeat (5) @(posedge clk);
        i_reset <= 1'b0;
        test_after_reset();
        test_fill_load();
        test_store();
        test_back_to_back();
        test_replace();
        test_line_end();
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
dcache_pkg.sv
dcache_ram.sv
dcache_ac.sv
dcache_dw.sv
dcache_top.sv
tb_dcache_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -x "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
